/* Bender.yml */
package:
  name: fsqrt

sources:
  # Packages first, then the stages and the top level
  - common/fp_fmt_pkg.sv
  - common/fsqrt_ctrl_pkg.sv
  - fsqrt/fsqrt_unpack.sv
  - fsqrt/fsqrt_recur.sv
  - fsqrt/fsqrt_round.sv
  - hdl/fsqrt_top.sv
  - target: simulation
    files:
      - dv/fsqrt_checker.sv
      - dv/fsqrt_tb.sv

/* common/fp_fmt_pkg.sv */
// ====================
// Single-precision format package
// Field widths, operand classes and the structs passed between sqrt stages
// ====================

package fp_fmt_pkg;

  // ====================
  // Format constants
  // ====================
  localparam int EXP_W  = 8;            // Exponent field
  localparam int MAN_W  = 23;           // Stored mantissa field
  localparam int BIAS   = 127;          // Exponent bias
  localparam int ROOT_W = MAN_W + 4;    // Implicit bit, mantissa, guard/round/sticky

  localparam logic [31:0] QNAN = 32'h7FC0_0000;  // Canonical quiet NaN

  // Operand class, decided once in the unpack stage
  typedef enum logic [2:0] {
    cls_normal = 3'd0,
    cls_zero   = 3'd1,                  // Zero or flushed subnormal
    cls_inf    = 3'd2,                  // Positive infinity only
    cls_nan    = 3'd3,
    cls_neg    = 3'd4                   // Nonzero negative, root is invalid
  } fp_class_e;

  // ====================
  // Stage payloads
  // ====================

  // Unpack to recurrence
  typedef struct packed {
    fp_class_e               cls;
    logic                    sign;      // Sign of a zero result
    logic [EXP_W-1:0]        exp_res;   // Halved and rebiased
    logic [2*ROOT_W-1:0]     radicand;  // Two integer bits, odd exponent pre-shifted
  } sqrt_unpacked_t;

  // Recurrence to round
  typedef struct packed {
    fp_class_e               cls;
    logic                    sign;
    logic [EXP_W-1:0]        exp_res;
    logic [ROOT_W-1:0]       root;      // Bit ROOT_W-1 is the implicit one
    logic                    sticky;    // Final remainder was nonzero
  } sqrt_root_t;

endpackage

/* common/fsqrt_ctrl_pkg.sv */
// ====================
// Square root control package
// Rounding modes, recurrence FSM states and exception flags
// ====================

package fsqrt_ctrl_pkg;

  // RISC-V rounding mode encoding, unlisted codes act as rtz
  typedef enum logic [2:0] {
    rm_rne = 3'd0,                      // Nearest, ties to even
    rm_rtz = 3'd1,                      // Toward zero
    rm_rdn = 3'd2,                      // Toward minus infinity
    rm_rup = 3'd3,                      // Toward plus infinity
    rm_rmm = 3'd4                       // Nearest, ties away from zero
  } fp_rm_e;

  // Recurrence engine FSM
  typedef enum logic [1:0] {
    r_idle = 2'd0,                      // Waiting, first iteration runs on accept
    r_iter = 2'd1,                      // One root bit per cycle
    r_emit = 2'd2                       // Root presented to the round stage
  } recur_state_e;

  // Exception flags raised by a square root
  typedef struct packed {
    logic nv;                           // Invalid, negative operand
    logic nx;                           // Inexact
  } fp_flags_t;

endpackage

/* dv/fsqrt_checker.sv */
// ====================
// Protocol checker for the square root top level
// Bound into fsqrt_top to watch busy, done and the held outputs
// ====================
`timescale 1ns/1ps

module fsqrt_checker (
  input logic        clk,
  input logic        reset_n,
  input logic        busy,
  input logic        done,
  input logic [31:0] result,
  input logic        flag_nv,
  input logic        flag_nx
);

  int unsigned assert_fails = 0;                    // Failure count

  // ====================
  // Done pulse
  // ====================
  done_one_cycle: assert property (@(posedge clk) disable iff (!reset_n) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      assert_fails++;
    end

  busy_drops: assert property (@(posedge clk) disable iff (!reset_n) done |=> !busy)
    else begin
      $error("busy still high on the cycle after done");
      assert_fails++;
    end

  // No result without an operation in flight
  done_needs_busy: assert property (@(posedge clk) disable iff (!reset_n) done |-> $past(busy))
    else begin
      $error("done rose without busy on the previous cycle");
      assert_fails++;
    end

  in_reset: assert property (@(posedge clk) !reset_n |-> (!busy && !done))
    else begin
      $error("busy or done high during reset");
      assert_fails++;
    end

  // Outputs change only together with done
  held_outputs: assert property (@(posedge clk) disable iff (!reset_n)
                                 !done |-> $stable({result, flag_nv, flag_nx}))
    else begin
      $error("result or flags changed while done was low");
      assert_fails++;
    end

endmodule

bind fsqrt_top fsqrt_checker u_checker (
  .clk     (clk),
  .reset_n (reset_n),
  .busy    (busy),
  .done    (done),
  .result  (result),
  .flag_nv (flag_nv),
  .flag_nx (flag_nx)
);

/* dv/fsqrt_tb.sv */
// ====================
// Testbench for the square root unit
// Reference model, directed and random operands, per-test report
// ====================
`timescale 1ns/1ps

module fsqrt_tb
  import fp_fmt_pkg::*;
  import fsqrt_ctrl_pkg::*;
();

  localparam int N_OPS      = 230;                  // Upper bound on operations issued
  localparam int MAX_CYCLES = 40 * N_OPS + 100;

  logic        clk;
  logic        reset_n;
  logic        start;
  fp_rm_e      rounding_mode;
  logic [31:0] operand;
  logic        busy;
  logic        done;
  logic [31:0] result;
  logic        flag_nv;
  logic        flag_nx;

  integer      seed = 32'h900f37ef;
  int          cycle_cnt = 0;
  int          test_errs = 0;                       // Errors in the running test
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  fp_rm_e      modes [5] = '{rm_rne, rm_rtz, rm_rdn, rm_rup, rm_rmm};

  fsqrt_top u_fsqrt_top (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .rounding_mode (rounding_mode),
    .operand       (operand),
    .busy          (busy),
    .done          (done),
    .result        (result),
    .flag_nv       (flag_nv),
    .flag_nx       (flag_nx)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                         // 100 ns period
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  // ====================
  // Reference model
  // ====================
  task automatic sqrt_model(input logic [31:0] op, input fp_rm_e rm,
                            output logic [31:0] res, output logic nv, output logic nx);
    int          e;
    int          b;
    logic [63:0] rad;                               // Significand scaled by 2^52
    logic [63:0] r;
    logic [63:0] cand;
    logic        g;
    logic        rd;
    logic        st;
    logic        up;
    nv  = 1'b0;
    nx  = 1'b0;
    res = '0;
    if (op[30:23] == 8'hFF && op[22:0] != '0) begin
      res = QNAN;
    end else if (op[30:23] == 8'h00) begin
      res = {op[31], 31'd0};                        // Zero or flushed subnormal
    end else if (op[31]) begin
      res = QNAN;
      nv  = 1'b1;
    end else if (op[30:23] == 8'hFF) begin
      res = 32'h7F80_0000;
    end else begin
      e   = int'(op[30:23]) - BIAS;
      rad = {40'd0, 1'b1, op[22:0]} << 29;
      if (e % 2 != 0) begin
        e   = e - 1;                                // Odd exponent folds into the mantissa
        rad = rad << 1;
      end
      r = '0;
      for (b = 26; b >= 0; b--) begin               // Greedy bit-by-bit integer root
        cand = r | (64'd1 << b);
        if (cand * cand <= rad)
          r = cand;
      end
      g  = r[2];
      rd = r[1];
      st = r[0] | (r * r != rad);
      case (rm)
        rm_rne:  up = g & (rd | st | r[3]);
        rm_rup:  up = g | rd | st;
        rm_rmm:  up = g;
        default: up = 1'b0;
      endcase
      res = {1'b0, 8'(e / 2 + BIAS), r[25:3]} + up;
      nx  = g | rd | st;
    end
  endtask

  // ====================
  // Stimulus and checks
  // ====================
  task automatic pulse_start(input logic [31:0] op, input fp_rm_e rm);
    @(posedge clk);
    #1;
    operand       = op;
    rounding_mode = rm;
    start         = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_done();
    @(negedge clk);
    while (!done)
      @(negedge clk);                               // Outputs settled mid-cycle
  endtask

  task automatic check_result(input logic [31:0] want, input logic want_nv,
                              input logic want_nx);
    assert (result === want) else begin
      $display("** Error at %0t: result expected %h, got %h", $time, want, result);
      test_errs++;
    end
    assert (flag_nv === want_nv) else begin
      $display("** Error at %0t: flag_nv expected %b, got %b", $time, want_nv, flag_nv);
      test_errs++;
    end
    assert (flag_nx === want_nx) else begin
      $display("** Error at %0t: flag_nx expected %b, got %b", $time, want_nx, flag_nx);
      test_errs++;
    end
  endtask

  task automatic check_op(input logic [31:0] op, input fp_rm_e rm,
                          input logic [31:0] want, input logic want_nv, input logic want_nx);
    pulse_start(op, rm);
    wait_done();
    check_result(want, want_nv, want_nx);
  endtask

  task automatic check_model(input logic [31:0] op, input fp_rm_e rm);
    logic [31:0] want;
    logic        want_nv;
    logic        want_nx;
    sqrt_model(op, rm, want, want_nv, want_nx);
    check_op(op, rm, want, want_nv, want_nx);
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("PASS  %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL  %s, %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    logic [31:0] op;
    logic [31:0] rnd;
    logic [31:0] r_rtz;
    logic [31:0] r_rdn;
    logic [31:0] r_rup;
    int          done_cnt;
    reset_n       = 1'b1;
    start         = 1'b0;
    operand       = '0;
    rounding_mode = rm_rne;
    #1 reset_n    = 1'b0;                           // Async reset edge before first clock
    repeat (3) @(posedge clk);
    #1 reset_n    = 1'b1;

    // Reset values, before any start
    @(negedge clk);
    assert (busy === 1'b0 && done === 1'b0) else begin
      $display("** Error at %0t: busy/done expected 0/0, got %b/%b", $time, busy, done);
      test_errs++;
    end
    check_result(32'h0, 1'b0, 1'b0);
    end_test("reset values");

    check_op(32'h7FC0_0000, rm_rne, QNAN, 1'b0, 1'b0);           // Quiet NaN
    check_op(32'hFF80_0001, rm_rne, QNAN, 1'b0, 1'b0);           // Negative NaN
    check_op(32'hC000_0000, rm_rne, QNAN, 1'b1, 1'b0);           // -2.0
    check_op(32'h7F80_0000, rm_rne, 32'h7F80_0000, 1'b0, 1'b0);
    check_op(32'h0000_0000, rm_rne, 32'h0000_0000, 1'b0, 1'b0);
    check_op(32'h8000_0000, rm_rne, 32'h8000_0000, 1'b0, 1'b0);
    check_op(32'h0000_0123, rm_rne, 32'h0000_0000, 1'b0, 1'b0);  // Subnormals
    check_op(32'h8040_0000, rm_rne, 32'h8000_0000, 1'b0, 1'b0);
    end_test("special operands");

    foreach (modes[i]) begin
      check_op(32'h4080_0000, modes[i], 32'h4000_0000, 1'b0, 1'b0);  // 4.0
      check_op(32'h3E80_0000, modes[i], 32'h3F00_0000, 1'b0, 1'b0);  // 0.25
      check_op(32'h4110_0000, modes[i], 32'h4040_0000, 1'b0, 1'b0);  // 9.0 has an odd exp
    end
    end_test("exact squares");

    repeat (200) begin
      rnd = $random(seed);
      op  = {1'b0, rnd[30:23] % 8'd254 + 8'd1, rnd[22:0]};          // Exponent 1..254
      check_model(op, rm_rne);
    end
    end_test("random normals rne");

    check_model(32'h4000_0000, rm_rtz);
    r_rtz = result;
    check_model(32'h4000_0000, rm_rdn);
    r_rdn = result;
    check_model(32'h4000_0000, rm_rup);
    r_rup = result;
    check_model(32'h4000_0000, rm_rmm);
    assert (r_rup == r_rtz + 1) else begin
      $display("** Error at %0t: rup result expected %h, got %h", $time, r_rtz + 1, r_rup);
      test_errs++;
    end
    assert (r_rdn == r_rtz) else begin
      $display("** Error at %0t: rdn result expected %h, got %h", $time, r_rtz, r_rdn);
      test_errs++;
    end
    end_test("directed rounding of sqrt 2");

    pulse_start(32'h4000_0000, rm_rne);
    repeat (2) @(posedge clk);
    pulse_start(32'h4110_0000, rm_rup);             // Lands while busy with another mode
    wait_done();
    sqrt_model(32'h4000_0000, rm_rne, op, r_rtz[0], r_rtz[1]);
    check_result(op, r_rtz[0], r_rtz[1]);
    done_cnt = 0;
    repeat (40) begin
      @(negedge clk);
      if (done)
        done_cnt++;
    end
    assert (done_cnt == 0) else begin
      $display("A second done pulse followed the ignored start");
      test_errs++;
    end
    end_test("start while busy");

    if (u_fsqrt_top.u_checker.assert_fails != 0)
      $display("Protocol assertions failed %0d times", u_fsqrt_top.u_checker.assert_fails);
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && u_fsqrt_top.u_checker.assert_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
common/fp_fmt_pkg.sv
common/fsqrt_ctrl_pkg.sv
fsqrt/fsqrt_unpack.sv
fsqrt/fsqrt_recur.sv
fsqrt/fsqrt_round.sv
hdl/fsqrt_top.sv
dv/fsqrt_checker.sv
dv/fsqrt_tb.sv

/* fsqrt/fsqrt_recur.sv */
// ====================
// Square root recurrence engine
// Restoring digit recurrence producing one of 27 root bits per cycle
// ====================
`timescale 1ns/1ps

module fsqrt_recur
  import fp_fmt_pkg::*;
  import fsqrt_ctrl_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,
  input  logic           unpk_valid,
  input  sqrt_unpacked_t unpk,
  output logic           root_valid,
  output sqrt_root_t     root
);

  recur_state_e                state;
  logic [$clog2(ROOT_W)-1:0]   iter_cnt;        // Iterations already done
  logic                        accept;          // New operation this cycle
  logic                        step;            // Iteration runs this cycle

  // Working registers
  logic [ROOT_W-1:0]           root_q;
  logic [ROOT_W+1:0]           rem_q;
  logic [2*ROOT_W-1:0]         rad_q;
  fp_class_e                   cls_q;
  logic                        sign_q;
  logic [EXP_W-1:0]            exp_q;

  // Iteration datapath
  logic [ROOT_W-1:0]           src_root;
  logic [ROOT_W+1:0]           src_rem;
  logic [2*ROOT_W-1:0]         src_rad;
  logic [ROOT_W+3:0]           ac;              // Remainder with two radicand bits
  logic [ROOT_W+3:0]           trial;           // Root shifted by two with a one appended
  logic [ROOT_W+3:0]           diff;
  logic                        fits;
  logic [ROOT_W-1:0]           nxt_root;
  logic [ROOT_W+1:0]           nxt_rem;

  assign accept = (state == r_idle) && unpk_valid;
  assign step   = accept || (state == r_iter);

  // ====================
  // One recurrence step
  // ====================
  always_comb begin
    // First step starts from zero root and remainder on the input radicand
    src_root = (state == r_idle) ? '0 : root_q;
    src_rem  = (state == r_idle) ? '0 : rem_q;
    src_rad  = (state == r_idle) ? unpk.radicand : rad_q;

    ac    = {src_rem, src_rad[2*ROOT_W-1 -: 2]};
    trial = {2'b00, src_root, 2'b01};
    diff  = ac - trial;
    fits  = (ac >= trial);                      // Difference non-negative

    nxt_rem  = fits ? diff[ROOT_W+1:0] : ac[ROOT_W+1:0];
    nxt_root = {src_root[ROOT_W-2:0], fits};
  end

  // ====================
  // FSM
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state    <= r_idle;
      iter_cnt <= '0;
    end else begin
      case (state)
        r_idle: begin
          if (unpk_valid) begin
            iter_cnt <= ($clog2(ROOT_W))'(1);   // First bit produced on accept
            state    <= (unpk.cls == cls_normal) ? r_iter : r_emit;
          end
        end
        r_iter: begin
          iter_cnt <= iter_cnt + 1'b1;
          if (iter_cnt == ($clog2(ROOT_W))'(ROOT_W-1))
            state <= r_emit;                    // Last bit lands this edge
        end
        r_emit:  state <= r_idle;
        default: state <= r_idle;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    if (step) begin
      root_q <= nxt_root;
      rem_q  <= nxt_rem;
      rad_q  <= src_rad << 2;                   // Next two radicand bits to the top
    end
    if (accept) begin
      cls_q  <= unpk.cls;
      sign_q <= unpk.sign;
      exp_q  <= unpk.exp_res;
    end
  end

  // Outputs held in r_emit for one cycle
  assign root_valid   = (state == r_emit);
  assign root.cls     = cls_q;
  assign root.sign    = sign_q;
  assign root.exp_res = exp_q;
  assign root.root    = root_q;
  assign root.sticky  = |rem_q;

endmodule

/* fsqrt/fsqrt_round.sv */
// ====================
// Square root round stage
// Rounds the root, packs result or special value, raises nv and nx
// ====================
`timescale 1ns/1ps

module fsqrt_round
  import fp_fmt_pkg::*;
  import fsqrt_ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  root_valid,
  input  sqrt_root_t            root,
  input  fp_rm_e                rm_q,
  output logic                  done,
  output logic [EXP_W+MAN_W:0]  result,
  output fp_flags_t             flags
);

  logic                     guard;
  logic                     rnd;
  logic                     sticky;
  logic                     round_up;
  logic [EXP_W+MAN_W-1:0]   mag;                // Exponent and mantissa after rounding
  logic [EXP_W+MAN_W:0]     nxt_result;
  fp_flags_t                nxt_flags;

  // ====================
  // Rounding decision
  // ====================
  assign guard  = root.root[2];
  assign rnd    = root.root[1];
  assign sticky = root.root[0] | root.sticky;   // Low root bit folds into sticky

  always_comb begin
    case (rm_q)
      rm_rne:  round_up = guard & (rnd | sticky | root.root[3]);
      rm_rup:  round_up = guard | rnd | sticky;
      rm_rmm:  round_up = guard;
      default: round_up = 1'b0;                 // rtz, rdn, root is never negative
    endcase
  end

  // Carry out of the mantissa would step the exponent
  assign mag = {root.exp_res, root.root[ROOT_W-2:3]} + round_up;

  // ====================
  // Result select
  // ====================
  always_comb begin
    nxt_flags = '0;
    case (root.cls)
      cls_nan: begin
        nxt_result = QNAN;
      end
      cls_neg: begin
        nxt_result   = QNAN;
        nxt_flags.nv = 1'b1;                    // sqrt of a negative
      end
      cls_inf: begin
        nxt_result = {1'b0, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
      end
      cls_zero: begin
        nxt_result = {root.sign, {(EXP_W+MAN_W){1'b0}}};  // Keeps minus zero
      end
      default: begin
        nxt_result   = {1'b0, mag};
        nxt_flags.nx = guard | rnd | sticky;
      end
    endcase
  end

  // Output registers, held between done pulses
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      done   <= 1'b0;
      result <= '0;
      flags  <= '0;
    end else begin
      done <= root_valid;                       // One-cycle pulse
      if (root_valid) begin
        result <= nxt_result;
        flags  <= nxt_flags;
      end
    end
  end

endmodule

/* fsqrt/fsqrt_unpack.sv */
// ====================
// Square root unpack stage
// Captures the operand, classifies it and builds radicand and exponent
// ====================
`timescale 1ns/1ps

module fsqrt_unpack
  import fp_fmt_pkg::*;
  import fsqrt_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   start,
  input  logic                   done,          // From round stage, ends the operation
  input  logic [EXP_W+MAN_W:0]   operand,
  input  fp_rm_e                 rounding_mode,
  output logic                   busy,
  output logic                   unpk_valid,
  output sqrt_unpacked_t         unpk,
  output fp_rm_e                 rm_q           // Stable for the whole operation
);

  logic                   start_ok;
  logic                   pend;                 // Operand captured, unpack next cycle
  logic [EXP_W+MAN_W:0]   op_q;
  logic                   op_sign;
  logic [EXP_W-1:0]       op_exp;
  logic [MAN_W-1:0]       op_man;
  logic [MAN_W:0]         sig;                  // Significand with implicit one
  logic signed [EXP_W+1:0] ue;                  // Unbiased exponent
  logic signed [EXP_W+1:0] ue_half;
  logic signed [EXP_W+1:0] exp_sum;
  sqrt_unpacked_t         nxt_unpk;

  assign start_ok = start & ~busy;              // Start while busy is dropped

  // ====================
  // Control
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy       <= 1'b0;
      pend       <= 1'b0;
      unpk_valid <= 1'b0;
    end else begin
      if (start_ok)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
      pend       <= start_ok;
      unpk_valid <= pend;                       // One-cycle pulse after capture
    end
  end

  // Operand and payload registers
  always_ff @(posedge clk) begin
    if (start_ok) begin
      op_q <= operand;
      rm_q <= rounding_mode;
    end
    if (pend)
      unpk <= nxt_unpk;
  end

  // ====================
  // Classify and prepare
  // ====================
  assign op_sign = op_q[EXP_W+MAN_W];
  assign op_exp  = op_q[MAN_W +: EXP_W];
  assign op_man  = op_q[MAN_W-1:0];
  assign sig     = {1'b1, op_man};

  always_comb begin
    ue      = $signed({2'b00, op_exp}) - $signed((EXP_W+2)'(BIAS));
    ue_half = ue >>> 1;                         // Floor halving, odd case is decremented first
    exp_sum = ue_half + $signed((EXP_W+2)'(BIAS));

    nxt_unpk.sign    = op_sign;
    nxt_unpk.exp_res = exp_sum[EXP_W-1:0];
    if (ue[0])                                  // Odd exponent, significand times two
      nxt_unpk.radicand = {sig, {(2*ROOT_W-MAN_W-1){1'b0}}};
    else
      nxt_unpk.radicand = {1'b0, sig, {(2*ROOT_W-MAN_W-2){1'b0}}};

    if (op_exp == {EXP_W{1'b1}} && op_man != '0)
      nxt_unpk.cls = cls_nan;                   // Any NaN, sign ignored
    else if (op_exp == '0)
      nxt_unpk.cls = cls_zero;                  // Subnormals flush to signed zero
    else if (op_sign)
      nxt_unpk.cls = cls_neg;                   // Includes minus infinity
    else if (op_exp == {EXP_W{1'b1}})
      nxt_unpk.cls = cls_inf;
    else
      nxt_unpk.cls = cls_normal;
  end

endmodule

/* hdl/fsqrt_top.sv */
// ====================
// Single-precision square root unit
// Unpack, digit recurrence and round stages in a chain
// ====================
`timescale 1ns/1ps

module fsqrt_top
  import fp_fmt_pkg::*;
  import fsqrt_ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start,          // Ignored while busy
  input  fp_rm_e                rounding_mode,
  input  logic [EXP_W+MAN_W:0]  operand,
  output logic                  busy,
  output logic                  done,           // One-cycle pulse
  output logic [EXP_W+MAN_W:0]  result,
  output logic                  flag_nv,
  output logic                  flag_nx
);

  // Stage links
  logic            unpk_valid;
  sqrt_unpacked_t  unpk;
  fp_rm_e          rm_q;
  logic            root_valid;
  sqrt_root_t      root;
  fp_flags_t       flags;

  // ====================
  // Stages
  // ====================
  fsqrt_unpack u_unpack (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .done          (done),
    .operand       (operand),
    .rounding_mode (rounding_mode),
    .busy          (busy),
    .unpk_valid    (unpk_valid),
    .unpk          (unpk),
    .rm_q          (rm_q)
  );

  fsqrt_recur u_recur (
    .clk        (clk),
    .reset_n    (reset_n),
    .unpk_valid (unpk_valid),
    .unpk       (unpk),
    .root_valid (root_valid),
    .root       (root)
  );

  fsqrt_round u_round (
    .clk        (clk),
    .reset_n    (reset_n),
    .root_valid (root_valid),
    .root       (root),
    .rm_q       (rm_q),
    .done       (done),
    .result     (result),
    .flags      (flags)
  );

  // Flag ports
  assign flag_nv = flags.nv;
  assign flag_nx = flags.nx;

endmodule
